// File: hdl/alu_other_config.svh
`ifndef ALU_OTHER_CONFIG_SVH
`define ALU_OTHER_CONFIG_SVH

// vector register width
`define VLEN 128
`define VLENB (`VLEN/8)

// scalar register width
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// index widths toward ROB and within a split instruction
`define ROB_DEPTH_WIDTH 3
`define UOP_INDEX_WIDTH 3

`endif

// File: hdl/alu_other_decode.sv
`timescale 1ns/1ns

module alu_other_decode (
  input  logic                        alu_uop_valid,
  input  alu_other_pkg::alu_uop_t     alu_uop,
  output alu_other_pkg::alu_decoded_t decoded
);

  localparam int VLEN  = $bits(rvv_isa_pkg::vreg_t);
  localparam int VLENB = $bits(alu_other_pkg::vmask_t);

  logic                   ok;
  logic                   factor4;
  alu_other_pkg::alu_op_e op;
  rvv_isa_pkg::vreg_t     src1;
  rvv_isa_pkg::vreg_t     src2;
  alu_other_pkg::vmask_t  mask;

  // scalar repeated across every element
  function automatic rvv_isa_pkg::vreg_t splat(rvv_isa_pkg::xreg_t x,
                                               rvv_isa_pkg::eew_e  eew);
    logic [31:0] word;
    case (eew)
      rvv_isa_pkg::EEW8:  word = {4{x[7:0]}};
      rvv_isa_pkg::EEW16: word = {2{x[15:0]}};
      rvv_isa_pkg::EEW32: word = x;
      default:            word = '0;
    endcase
    return {(VLEN/32){word}};
  endfunction

  // element 0 only with the rest of the register zero
  function automatic rvv_isa_pkg::vreg_t low_elem(logic [31:0] x,
                                                  rvv_isa_pkg::eew_e eew);
    rvv_isa_pkg::vreg_t v;
    v = '0;
    case (eew)
      rvv_isa_pkg::EEW8:  v[7:0]  = x[7:0];
      rvv_isa_pkg::EEW16: v[15:0] = x[15:0];
      rvv_isa_pkg::EEW32: v[31:0] = x;
      default:            v = '0;
    endcase
    return v;
  endfunction

  always_comb begin
    ok      = 1'b0;
    op      = alu_other_pkg::OP_NONE;
    factor4 = 1'b0;
    src1    = '0;
    src2    = '0;
    case (alu_uop.funct3)
      rvv_isa_pkg::OPIVV, rvv_isa_pkg::OPIVX, rvv_isa_pkg::OPIVI: begin
        if (alu_uop.funct6 == rvv_isa_pkg::VMERGE_VMV) begin
          // vmv.v when vm is set and vmerge otherwise
          ok = ((alu_uop.funct3 == rvv_isa_pkg::OPIVV) ? alu_uop.vs1_data_valid :
                                                         alu_uop.rs1_data_valid) &
               (alu_uop.vm | (alu_uop.vs2_data_valid & alu_uop.v0_data_valid));
          op   = alu_uop.vm ? alu_other_pkg::OP_MOVE : alu_other_pkg::OP_MERGE;
          src2 = alu_uop.vs2_data;
          if (alu_uop.funct3 == rvv_isa_pkg::OPIVV) begin
            src1 = alu_uop.vs1_data;
          end else begin
            src1 = splat(alu_uop.rs1_data, alu_uop.vm ? alu_uop.vd_eew : alu_uop.vs2_eew);
          end
        end else if (alu_uop.funct3 == rvv_isa_pkg::OPIVI &&
                     alu_uop.funct6 == rvv_isa_pkg::VSMUL_VMVNRR) begin
          // whole register move
          ok   = alu_uop.vm & alu_uop.vs2_data_valid;
          op   = alu_other_pkg::OP_COPY_SRC2;
          src2 = alu_uop.vs2_data;
        end
      end
      rvv_isa_pkg::OPMVV: begin
        if (alu_uop.funct6 == rvv_isa_pkg::VXUNARY0) begin
          case (alu_uop.vs1_code)
            rvv_isa_pkg::VZEXT_VF2, rvv_isa_pkg::VSEXT_VF2: begin
              ok = ~alu_uop.vs1_data_valid & alu_uop.vs2_data_valid &
                   (alu_uop.vs2_eew == rvv_isa_pkg::EEW8 ||
                    alu_uop.vs2_eew == rvv_isa_pkg::EEW16);
              op = (alu_uop.vs1_code == rvv_isa_pkg::VSEXT_VF2) ? alu_other_pkg::OP_SEXT :
                                                                  alu_other_pkg::OP_ZEXT;
              // half of vs2 picked by the uop index
              src2 = {{(VLEN/2){1'b0}},
                      alu_uop.vs2_data[alu_uop.uop_index[0]*(VLEN/2) +: VLEN/2]};
            end
            rvv_isa_pkg::VZEXT_VF4, rvv_isa_pkg::VSEXT_VF4: begin
              ok = ~alu_uop.vs1_data_valid & alu_uop.vs2_data_valid &
                   (alu_uop.vs2_eew == rvv_isa_pkg::EEW8);
              op = (alu_uop.vs1_code == rvv_isa_pkg::VSEXT_VF4) ? alu_other_pkg::OP_SEXT :
                                                                  alu_other_pkg::OP_ZEXT;
              factor4 = 1'b1;
              src2 = {{(VLEN*3/4){1'b0}},
                      alu_uop.vs2_data[alu_uop.uop_index[1:0]*(VLEN/4) +: VLEN/4]};
            end
            default: ok = 1'b0;
          endcase
        end else if (alu_uop.funct6 == rvv_isa_pkg::VWRXUNARY0) begin
          // vmv.x.s
          ok   = alu_uop.vm & alu_uop.vs2_data_valid &
                 (alu_uop.vs1_code == rvv_isa_pkg::VMV_X_S);
          op   = alu_other_pkg::OP_COPY_SRC2;
          src2 = low_elem(alu_uop.vs2_data[31:0], alu_uop.vs2_eew);
        end
      end
      rvv_isa_pkg::OPMVX: begin
        if (alu_uop.funct6 == rvv_isa_pkg::VWRXUNARY0) begin
          // vmv.s.x
          ok   = alu_uop.vm & alu_uop.rs1_data_valid;
          op   = alu_other_pkg::OP_MOVE;
          src1 = low_elem(alu_uop.rs1_data, alu_uop.vd_eew);
        end
      end
      default: ok = 1'b0;
    endcase
  end

  // v0 bits for the elements of this uop
  always_comb begin
    case (alu_uop.vs2_eew)
      rvv_isa_pkg::EEW8: mask = alu_uop.v0_data[alu_uop.uop_index*VLENB +: VLENB];
      rvv_isa_pkg::EEW16: mask = {{(VLENB/2){1'b0}},
                                  alu_uop.v0_data[alu_uop.uop_index*(VLENB/2) +: VLENB/2]};
      rvv_isa_pkg::EEW32: mask = {{(VLENB*3/4){1'b0}},
                                  alu_uop.v0_data[alu_uop.uop_index*(VLENB/4) +: VLENB/4]};
      default: mask = '0;
    endcase
  end

  always_comb begin
    decoded.valid     = alu_uop_valid & ok;
    decoded.op        = op;
    decoded.rob_entry = alu_uop.rob_entry;
    decoded.eew       = alu_uop.vs2_eew;
    decoded.factor4   = factor4;
    decoded.src1      = src1;
    decoded.src2      = src2;
    decoded.mask      = mask;
  end

endmodule

// File: hdl/alu_other_execute.sv
`timescale 1ns/1ns

`include "alu_other_config.svh"

module alu_other_execute (
  input  alu_other_pkg::alu_decoded_t decoded,
  output alu_other_pkg::alu_lanes_t   lanes
);

  localparam int WORDS = `VLEN/`WORD_WIDTH;

  wire [`VLEN-1:0] ext_data;
  wire [`VLEN-1:0] merge_data;

  genvar j;

  generate
    for (j = 0; j < WORDS; j++) begin : g_word
      logic                    sx;
      logic [`BYTE_WIDTH-1:0]  q;
      logic [`BYTE_WIDTH-1:0]  b0;
      logic [`BYTE_WIDTH-1:0]  b1;
      logic [`HWORD_WIDTH-1:0] h;
      logic [`WORD_WIDTH-1:0]  ext_w;
      logic [`WORD_WIDTH-1:0]  merge_w;

      // source elements feeding this destination word
      assign sx = (decoded.op == alu_other_pkg::OP_SEXT);
      assign q  = decoded.src2[j*`BYTE_WIDTH +: `BYTE_WIDTH];
      assign b0 = decoded.src2[(2*j)*`BYTE_WIDTH +: `BYTE_WIDTH];
      assign b1 = decoded.src2[(2*j+1)*`BYTE_WIDTH +: `BYTE_WIDTH];
      assign h  = decoded.src2[j*`HWORD_WIDTH +: `HWORD_WIDTH];

      always_comb begin
        ext_w = '0;
        if (decoded.factor4) begin
          ext_w = {{24{sx & q[7]}}, q};
        end else if (decoded.eew == rvv_isa_pkg::EEW8) begin
          ext_w = {{8{sx & b1[7]}}, b1, {8{sx & b0[7]}}, b0};
        end else if (decoded.eew == rvv_isa_pkg::EEW16) begin
          ext_w = {{16{sx & h[15]}}, h};
        end
      end

      // mask bit 1 takes src1
      always_comb begin
        merge_w = '0;
        case (decoded.eew)
          rvv_isa_pkg::EEW8: begin
            for (int k = 0; k < 4; k++) begin
              merge_w[k*`BYTE_WIDTH +: `BYTE_WIDTH] = decoded.mask[4*j+k] ?
                decoded.src1[(4*j+k)*`BYTE_WIDTH +: `BYTE_WIDTH] :
                decoded.src2[(4*j+k)*`BYTE_WIDTH +: `BYTE_WIDTH];
            end
          end
          rvv_isa_pkg::EEW16: begin
            for (int k = 0; k < 2; k++) begin
              merge_w[k*`HWORD_WIDTH +: `HWORD_WIDTH] = decoded.mask[2*j+k] ?
                decoded.src1[(2*j+k)*`HWORD_WIDTH +: `HWORD_WIDTH] :
                decoded.src2[(2*j+k)*`HWORD_WIDTH +: `HWORD_WIDTH];
            end
          end
          rvv_isa_pkg::EEW32: begin
            merge_w = decoded.mask[j] ? decoded.src1[j*`WORD_WIDTH +: `WORD_WIDTH] :
                                        decoded.src2[j*`WORD_WIDTH +: `WORD_WIDTH];
          end
          default: merge_w = '0;
        endcase
      end

      assign ext_data[j*`WORD_WIDTH +: `WORD_WIDTH]   = ext_w;
      assign merge_data[j*`WORD_WIDTH +: `WORD_WIDTH] = merge_w;
    end
  endgenerate

  assign lanes.ext_data   = ext_data;
  assign lanes.merge_data = merge_data;

  // only the 8 to 32 bit lanes exist for factor 4
  assert final (!(decoded.valid && decoded.factor4) || decoded.eew == rvv_isa_pkg::EEW8)
    else $error("factor 4 extension issued with a source wider than 8 bits");

  // decode passes vs2_eew through unchecked for vmerge
  assert final (!(decoded.valid && decoded.op == alu_other_pkg::OP_MERGE) ||
                decoded.eew inside {rvv_isa_pkg::EEW8, rvv_isa_pkg::EEW16,
                                    rvv_isa_pkg::EEW32})
    else $error("vmerge issued with an unsupported element width");

endmodule

// File: hdl/alu_other_pkg.sv
`include "alu_other_config.svh"

package alu_other_pkg;

  // one mask bit per byte lane
  typedef logic [`VLENB-1:0] vmask_t;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_MOVE,
    OP_MERGE,
    OP_ZEXT,
    OP_SEXT,
    OP_COPY_SRC2
  } alu_op_e;

  // micro-op from the ALU reservation station
  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    rvv_isa_pkg::funct6_e        funct6;
    rvv_isa_pkg::funct3_e        funct3;
    logic                        vm;
    rvv_isa_pkg::eew_e           vd_eew;
    rvv_isa_pkg::vs1_code_e      vs1_code;
    rvv_isa_pkg::vreg_t          v0_data;
    logic                        v0_data_valid;
    rvv_isa_pkg::vreg_t          vs1_data;
    logic                        vs1_data_valid;
    rvv_isa_pkg::vreg_t          vs2_data;
    logic                        vs2_data_valid;
    rvv_isa_pkg::eew_e           vs2_eew;
    rvv_isa_pkg::xreg_t          rs1_data;
    logic                        rs1_data_valid;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
  } alu_uop_t;

  typedef struct packed {
    logic                        valid;
    alu_op_e                     op;
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    rvv_isa_pkg::eew_e           eew;
    logic                        factor4;
    rvv_isa_pkg::vreg_t          src1;
    rvv_isa_pkg::vreg_t          src2;
    vmask_t                      mask;
  } alu_decoded_t;

  typedef struct packed {
    rvv_isa_pkg::vreg_t ext_data;
    rvv_isa_pkg::vreg_t merge_data;
  } alu_lanes_t;

  // write-back toward the ROB
  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    rvv_isa_pkg::vreg_t          w_data;
  } alu_result_t;

endpackage

// File: hdl/alu_other_result.sv
`timescale 1ns/1ns

module alu_other_result (
  input  logic                        clk,
  input  logic                        rst_n,
  input  alu_other_pkg::alu_decoded_t decoded,
  input  alu_other_pkg::alu_lanes_t   lanes,
  output logic                        result_valid,
  output alu_other_pkg::alu_result_t  result
);

  rvv_isa_pkg::vreg_t w_data;

  always_comb begin
    case (decoded.op)
      alu_other_pkg::OP_MOVE:      w_data = decoded.src1;
      alu_other_pkg::OP_COPY_SRC2: w_data = decoded.src2;
      alu_other_pkg::OP_MERGE:     w_data = lanes.merge_data;
      alu_other_pkg::OP_ZEXT,
      alu_other_pkg::OP_SEXT:      w_data = lanes.ext_data;
      default:                     w_data = '0;
    endcase
  end

  // single pipeline register toward the ROB
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= decoded.valid;
    end
    result.rob_entry <= decoded.rob_entry;
    result.w_data    <= w_data;
  end

  // the default branch would write zeros for an accepted micro-op
  assert property (@(posedge clk) disable iff (!rst_n)
                   decoded.valid |-> decoded.op != alu_other_pkg::OP_NONE)
    else $error("valid micro-op decoded without an operation");

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(decoded.valid))
    else $error("decoded valid is unknown out of reset");

endmodule

// File: hdl/alu_other_unit.sv
`timescale 1ns/1ns

module alu_other_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       alu_uop_valid,
  input  alu_other_pkg::alu_uop_t    alu_uop,
  output logic                       result_valid,
  output alu_other_pkg::alu_result_t result
);

  alu_other_pkg::alu_decoded_t decoded;
  alu_other_pkg::alu_lanes_t   lanes;

  alu_other_decode i_decode (
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .decoded       (decoded)
  );

  alu_other_execute i_execute (
    .decoded (decoded),
    .lanes   (lanes)
  );

  alu_other_result i_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .decoded      (decoded),
    .lanes        (lanes),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// File: hdl/rvv_isa_pkg.sv
`include "alu_other_config.svh"

package rvv_isa_pkg;

  // architectural register containers
  typedef logic [`VLEN-1:0] vreg_t;
  typedef logic [`XLEN-1:0] xreg_t;

  // operand category of an arithmetic instruction
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  // only the codes handled by this unit
  typedef enum logic [5:0] {
    VWRXUNARY0   = 6'b010000,
    VXUNARY0     = 6'b010010,
    VMERGE_VMV   = 6'b010111,
    VSMUL_VMVNRR = 6'b100111
  } funct6_e;

  // vs1 field reused as a sub-opcode for unary ops
  typedef enum logic [4:0] {
    VMV_X_S   = 5'b00000,
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } vs1_code_e;

  // effective element width
  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the alu_other testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_alu_other -f src.f -o sim_alu_other

./obj_dir/sim_alu_other | tee sim.log

if grep -qx "Regression passed" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: src.f
+incdir+hdl
hdl/rvv_isa_pkg.sv
hdl/alu_other_pkg.sv
hdl/alu_other_decode.sv
hdl/alu_other_execute.sv
hdl/alu_other_result.sv
hdl/alu_other_unit.sv
verification/alu_other_checker.sv
verification/tb_alu_other.sv

// File: verification/alu_other_checker.sv
`timescale 1ns/1ns

`include "alu_other_config.svh"

module alu_other_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       alu_uop_valid,
  input  alu_other_pkg::alu_uop_t    alu_uop,
  input  logic                       result_valid,
  input  alu_other_pkg::alu_result_t result,
  input  logic [2:0]                 phase,
  input  logic                       phase_end,
  output int                         phases_done,
  output int                         total_checks,
  output int                         total_errors
);

  string names [6] = '{"reset", "vmv_v", "vmerge", "extend", "scalar_and_whole_moves",
                       "invalid"};

  logic                        exp_known;
  logic                        exp_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] exp_rob;
  rvv_isa_pkg::vreg_t          exp_data;
  rvv_isa_pkg::vreg_t          pred_data;
  logic                        pred_ok;
  logic                        phase_end_q;
  int                          checks;
  int                          errors;

  // expected valid and data from the instruction rules
  function automatic logic predict(input alu_other_pkg::alu_uop_t u,
                                   output rvv_isa_pkg::vreg_t d);
    logic ok;
    logic sext;
    int   w;
    int   f;
    int   base;
    int   pos;
    ok = 1'b0;
    d  = '0;
    w  = 8 << int'(u.vs2_eew);
    if (u.funct6 == rvv_isa_pkg::VMERGE_VMV && u.funct3 inside {rvv_isa_pkg::OPIVV,
        rvv_isa_pkg::OPIVX, rvv_isa_pkg::OPIVI}) begin
      ok = (u.funct3 == rvv_isa_pkg::OPIVV ? u.vs1_data_valid : u.rs1_data_valid) &&
           (u.vm || (u.vs2_data_valid && u.v0_data_valid));
      w  = 8 << int'(u.vm ? u.vd_eew : u.vs2_eew);
      // v0 bits start uop_index register-fulls of elements in
      for (int b = 0; b < `VLEN; b++) begin
        if (!u.vm && !u.v0_data[int'(u.uop_index) * (`VLEN / w) + b / w]) begin
          d[b] = u.vs2_data[b];
        end else begin
          d[b] = (u.funct3 == rvv_isa_pkg::OPIVV) ? u.vs1_data[b] : u.rs1_data[b % w];
        end
      end
    end else if (u.funct3 == rvv_isa_pkg::OPMVV && u.funct6 == rvv_isa_pkg::VXUNARY0) begin
      f    = (u.vs1_code inside {rvv_isa_pkg::VZEXT_VF4, rvv_isa_pkg::VSEXT_VF4}) ? 4 : 2;
      sext = (u.vs1_code inside {rvv_isa_pkg::VSEXT_VF2, rvv_isa_pkg::VSEXT_VF4});
      ok   = (u.vs1_code inside {rvv_isa_pkg::VZEXT_VF2, rvv_isa_pkg::VSEXT_VF2,
                                 rvv_isa_pkg::VZEXT_VF4, rvv_isa_pkg::VSEXT_VF4}) &&
             !u.vs1_data_valid && u.vs2_data_valid &&
             (f == 4 ? u.vs2_eew == rvv_isa_pkg::EEW8 :
                       u.vs2_eew inside {rvv_isa_pkg::EEW8, rvv_isa_pkg::EEW16});
      base = (f == 4 ? int'(u.uop_index[1:0]) : int'(u.uop_index[0])) * (`VLEN / f);
      for (int b = 0; b < `VLEN && ok; b++) begin
        // bits above the source width repeat its top bit
        pos  = base + (b / (w * f)) * w + ((b % (w * f)) < w ? b % (w * f) : w - 1);
        d[b] = ((b % (w * f)) < w || sext) ? u.vs2_data[pos] : 1'b0;
      end
    end else if (u.funct3 == rvv_isa_pkg::OPIVI && u.funct6 == rvv_isa_pkg::VSMUL_VMVNRR) begin
      ok = u.vm && u.vs2_data_valid;
      d  = u.vs2_data;
    end else if (u.funct3 == rvv_isa_pkg::OPMVV && u.funct6 == rvv_isa_pkg::VWRXUNARY0) begin
      ok = u.vm && u.vs2_data_valid && u.vs1_code == rvv_isa_pkg::VMV_X_S;
      for (int b = 0; b < w; b++) begin
        d[b] = u.vs2_data[b];
      end
    end else if (u.funct3 == rvv_isa_pkg::OPMVX && u.funct6 == rvv_isa_pkg::VWRXUNARY0) begin
      ok = u.vm && u.rs1_data_valid;
      w  = 8 << int'(u.vd_eew);
      for (int b = 0; b < w; b++) begin
        d[b] = u.rs1_data[b];
      end
    end
    return ok;
  endfunction

  task automatic count_check(input string name, input rvv_isa_pkg::vreg_t exp,
                             input rvv_isa_pkg::vreg_t act);
    checks++;
    total_checks++;
    if (act !== exp) begin
      errors++;
      total_errors++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  initial begin
    exp_known    = 1'b0;
    phase_end_q  = 1'b0;
    checks       = 0;
    errors       = 0;
    phases_done  = 0;
    total_checks = 0;
    total_errors = 0;
  end

  // inputs are stable at the rising edge
  always @(posedge clk) begin
    pred_ok   = predict(alu_uop, pred_data);
    exp_known = 1'b1;
    exp_valid = rst_n && alu_uop_valid && pred_ok;
    exp_rob   = alu_uop.rob_entry;
    exp_data  = pred_data;
    if (phase_end && !phase_end_q) begin
      $display("test %0d %s: %0d checks, %0d errors, %s", phase, names[phase],
               checks, errors, (errors == 0) ? "ok" : "mismatches");
      checks      = 0;
      errors      = 0;
      phases_done = phases_done + 1;
    end
    phase_end_q = phase_end;
  end

  // registered outputs compared half a cycle later
  always @(negedge clk) begin
    if (exp_known) begin
      count_check("result_valid", rvv_isa_pkg::vreg_t'(exp_valid),
                  rvv_isa_pkg::vreg_t'(result_valid));
      if (exp_valid) begin
        count_check("result.rob_entry", rvv_isa_pkg::vreg_t'(exp_rob),
                    rvv_isa_pkg::vreg_t'(result.rob_entry));
        count_check("result.w_data", exp_data, result.w_data);
      end
    end
  end

endmodule

// File: verification/tb_alu_other.sv
`timescale 1ns/1ns

`include "alu_other_config.svh"

module tb_alu_other;

  localparam int RESET_CYCLES   = 16;
  localparam int OPS_PER_TEST   = 200;
  localparam int TIMEOUT_CYCLES = 50;

  logic                       clk;
  logic                       rst_n;
  logic                       alu_uop_valid;
  alu_other_pkg::alu_uop_t    alu_uop;
  logic                       result_valid;
  alu_other_pkg::alu_result_t result;
  logic [2:0]                 phase;
  logic                       phase_end;
  logic                       timed_out;
  int                         phases_done;
  int                         total_checks;
  int                         total_errors;

  alu_other_unit i_alu_other_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .result_valid  (result_valid),
    .result        (result)
  );

  alu_other_checker i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_uop_valid (alu_uop_valid),
    .alu_uop       (alu_uop),
    .result_valid  (result_valid),
    .result        (result),
    .phase         (phase),
    .phase_end     (phase_end),
    .phases_done   (phases_done),
    .total_checks  (total_checks),
    .total_errors  (total_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // random micro-op of one test class with operand valids mostly set
  function automatic alu_other_pkg::alu_uop_t random_uop(input int cls);
    alu_other_pkg::alu_uop_t u;
    logic [31:0]             r;
    int                      pick;
    for (int i = 0; i < $bits(u); i++) begin
      r    = $urandom;
      u[i] = r[0];
    end
    pick             = $urandom_range(0, 3);
    u.vm             = ($urandom_range(0, 7) != 0);
    u.v0_data_valid  = ($urandom_range(0, 7) != 0);
    u.vs1_data_valid = ($urandom_range(0, 7) != 0);
    u.vs2_data_valid = ($urandom_range(0, 7) != 0);
    u.rs1_data_valid = ($urandom_range(0, 7) != 0);
    u.vd_eew         = rvv_isa_pkg::eew_e'(2'($urandom_range(0, 2)));
    u.vs2_eew        = rvv_isa_pkg::eew_e'(2'($urandom_range(0, 2)));
    case (cls)
      1, 2: begin
        u.funct6 = rvv_isa_pkg::VMERGE_VMV;
        u.funct3 = (pick == 0) ? rvv_isa_pkg::OPIVV :
                   (pick == 1) ? rvv_isa_pkg::OPIVX : rvv_isa_pkg::OPIVI;
        u.vm     = (cls == 1);
      end
      3: begin
        u.funct3         = rvv_isa_pkg::OPMVV;
        u.funct6         = rvv_isa_pkg::VXUNARY0;
        u.vs1_code       = (pick == 0) ? rvv_isa_pkg::VZEXT_VF2 :
                           (pick == 1) ? rvv_isa_pkg::VSEXT_VF2 :
                           (pick == 2) ? rvv_isa_pkg::VZEXT_VF4 : rvv_isa_pkg::VSEXT_VF4;
        u.vs1_data_valid = ($urandom_range(0, 7) == 0);
        // mostly legal source widths
        if ($urandom_range(0, 7) != 0) begin
          u.vs2_eew = (pick < 2) ? rvv_isa_pkg::eew_e'(2'($urandom_range(0, 1))) :
                                   rvv_isa_pkg::EEW8;
        end
      end
      4: begin
        // whole register move, vmv.s.x, vmv.x.s
        u.funct6 = (pick == 0) ? rvv_isa_pkg::VSMUL_VMVNRR : rvv_isa_pkg::VWRXUNARY0;
        u.funct3 = (pick == 0) ? rvv_isa_pkg::OPIVI :
                   (pick == 1) ? rvv_isa_pkg::OPMVX : rvv_isa_pkg::OPMVV;
        if ($urandom_range(0, 7) != 0) begin
          u.vs1_code = rvv_isa_pkg::VMV_X_S;
        end
      end
      default: begin
        u.funct6 = rvv_isa_pkg::VXUNARY0;
        u.funct3 = rvv_isa_pkg::OPMVV;
        case (pick)
          0: begin
            u.funct6         = rvv_isa_pkg::VMERGE_VMV;
            u.funct3         = rvv_isa_pkg::OPIVV;
            u.vm             = 1'b1;
            u.vs1_data_valid = 1'b0;
          end
          1: begin
            u.funct6 = rvv_isa_pkg::VSMUL_VMVNRR;
            u.funct3 = rvv_isa_pkg::OPIVI;
            u.vm     = 1'b0;
          end
          2: begin
            u.vs1_code       = rvv_isa_pkg::VZEXT_VF4;
            u.vs1_data_valid = 1'b0;
            u.vs2_eew        = ($urandom_range(0, 1) != 0) ? rvv_isa_pkg::EEW16 :
                                                             rvv_isa_pkg::EEW32;
          end
          default: begin
            u.funct6 = rvv_isa_pkg::funct6_e'(6'b000000);
            u.funct3 = rvv_isa_pkg::funct3_e'(3'($urandom_range(0, 7)));
          end
        endcase
      end
    endcase
    return u;
  endfunction

  // ends the current test and waits for its report line
  task automatic finish_test();
    int waited;
    @(posedge clk);
    #2;
    alu_uop_valid = 1'b0;
    phase_end     = 1'b1;
    waited        = 0;
    while (phases_done <= int'(phase) && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (phases_done <= int'(phase)) begin
      $display("timeout: the checker did not report test %0d", phase);
      timed_out = 1'b1;
    end
    #2;
    phase_end = 1'b0;
  endtask

  initial begin
    int waited;
    void'($urandom(42));
    rst_n         = 1'b0;
    alu_uop_valid = 1'b0;
    alu_uop       = '0;
    phase         = 3'd0;
    phase_end     = 1'b0;
    timed_out     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n  = 1'b1;
    waited = 0;
    while (result_valid !== 1'b0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (result_valid !== 1'b0) begin
      $display("timeout: result_valid did not settle low after reset release");
      timed_out = 1'b1;
    end
    finish_test();
    for (int cls = 1; cls <= 5 && !timed_out; cls++) begin
      phase = 3'(cls);
      repeat (OPS_PER_TEST) begin
        @(posedge clk);
        #2;
        alu_uop_valid = ($urandom_range(0, 7) != 0);
        alu_uop       = random_uop(cls);
      end
      finish_test();
    end
    $display("summary: %0d tests, %0d checks, %0d errors",
             phases_done, total_checks, total_errors);
    if (!timed_out && total_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
